// File: fpAddSub.f
+incdir+logic
+incdir+verification
logic/fpFormatPkg.sv
logic/fpAddCtrlPkg.sv
logic/fpPrealign.sv
logic/fpAlign.sv
logic/fpExecute.sv
logic/fpNormalizeRound.sv
logic/fpAddSub.sv
verification/fpAddSubTb.sv

// File: logic/fpAddCtrlPkg.sv
`default_nettype none

package fpAddCtrlPkg;

	// Requested operation
	typedef enum logic {
		opAdd = 1'b0,  // a + b
		opSub = 1'b1   // a - b
	} fpOp_e;

	// Input exception vector, same bit order as the prealign block
	typedef struct packed {
		logic anyExc;  // Some input is NaN or infinity
		logic aNaN;    // A is NaN
		logic bNaN;    // B is NaN
		logic aInf;    // A is infinity
		logic bInf;    // B is infinity
	} inputExc_t;

	// Result status
	typedef struct packed {
		logic invalid;    // NaN produced
		logic overflow;   // Rounded to infinity
		logic underflow;  // Flushed to zero
	} resultFlags_t;

endpackage

`default_nettype wire

// File: logic/fpAddSub.sv
`timescale 1ns/1ps
`include "fpAdd_macros.svh"
`default_nettype none

module fpAddSub (
	input  logic                        clk,
	input  logic                        rstN,
	input  logic                        inVal,   // One strobe per operand pair
	input  fpFormatPkg::fpWord_u        a,
	input  fpFormatPkg::fpWord_u        b,
	input  fpAddCtrlPkg::fpOp_e         op,
	output logic                        outVal,  // inVal delayed by 3
	output fpFormatPkg::fpWord_u        result,
	output fpAddCtrlPkg::resultFlags_t  flags
);
	import fpFormatPkg::*;
	import fpAddCtrlPkg::*;

	// Stage 0, combinational
	logic                   signA, signB;
	logic [2*`FP_EXP_W-1:0] shiftDet;
	inputExc_t              preExc;
	fpMag_t                 magA, magB;
	fpOp_e                  preOp, alnOp;
	logic [`FP_SIG_W-1:0]   alnLarge, alnSmall;
	logic [`FP_EXP_W-1:0]   alnExp;
	logic                   alnLargeSign, alnSmallSign;

	// Stage 1 registers
	logic                   s1Val;
	logic [`FP_SIG_W-1:0]   s1Large, s1Small;
	logic [`FP_EXP_W-1:0]   s1Exp;
	logic                   s1LargeSign, s1SmallSign;
	logic                   s1SignA, s1SignB;  // Needed for infinity sign
	fpOp_e                  s1Op;
	inputExc_t              s1Exc;

	// Stage 2 registers
	logic                   s2Val;
	logic [`FP_SIG_W:0]     exeSum, s2Sum;
	logic                   exeSign, s2Sign;
	logic [`FP_EXP_W-1:0]   s2Exp;
	logic                   s2SignA, s2SignB;
	fpOp_e                  s2Op;
	inputExc_t              s2Exc;

	// Stage 3 inputs
	fpWord_u                nrmResult;
	resultFlags_t           nrmFlags;

	fpPrealign u_prealign (.a(a), .b(b), .op(op), .signA(signA), .signB(signB),
		.shiftDet(shiftDet), .inputExc(preExc), .magA(magA), .magB(magB), .opOut(preOp));

	fpAlign u_align (.signA(signA), .signB(signB), .shiftDet(shiftDet), .magA(magA),
		.magB(magB), .opIn(preOp), .largeMan(alnLarge), .smallMan(alnSmall), .baseExp(alnExp),
		.largeSign(alnLargeSign), .smallSign(alnSmallSign), .opOut(alnOp));

	fpExecute u_execute (.largeMan(s1Large), .smallMan(s1Small), .largeSign(s1LargeSign),
		.smallSign(s1SmallSign), .op(s1Op), .sumMan(exeSum), .sumSign(exeSign));

	fpNormalizeRound u_normRound (.sumMan(s2Sum), .sumSign(s2Sign), .baseExp(s2Exp),
		.inputExc(s2Exc), .signA(s2SignA), .signB(s2SignB), .op(s2Op),
		.result(nrmResult), .flags(nrmFlags));

	// Valid chain, the only reset state
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			s1Val  <= 1'b0;
			s2Val  <= 1'b0;
			outVal <= 1'b0;
		end else begin
			s1Val  <= inVal;
			s2Val  <= s1Val;
			outVal <= s2Val;
		end
	end

	// Payload, loads only with its strobe
	always_ff @(posedge clk) begin
		if (inVal) begin
			s1Large     <= alnLarge;
			s1Small     <= alnSmall;
			s1Exp       <= alnExp;
			s1LargeSign <= alnLargeSign;
			s1SmallSign <= alnSmallSign;
			s1SignA     <= signA;
			s1SignB     <= signB;
			s1Op        <= alnOp;
			s1Exc       <= preExc;
		end
		if (s1Val) begin
			s2Sum   <= exeSum;
			s2Sign  <= exeSign;
			s2Exp   <= s1Exp;
			s2SignA <= s1SignA;
			s2SignB <= s1SignB;
			s2Op    <= s1Op;
			s2Exc   <= s1Exc;
		end
		if (s2Val) begin
			result <= nrmResult;
			flags  <= nrmFlags;
		end
	end

endmodule

`default_nettype wire

// File: logic/fpAdd_macros.svh
`ifndef FPADD_MACROS_SVH
`define FPADD_MACROS_SVH

`default_nettype none

// binary16 layout
`define FP_WIDTH 16   // Whole word
`define FP_EXP_W 5    // Exponent field
`define FP_MAN_W 10   // Stored mantissa field
`define FP_BIAS  15   // Exponent bias
`define FP_GRS_W 3    // Guard, round and sticky

// Derived widths
`define FP_SIG_W (`FP_MAN_W+`FP_GRS_W+1)  // Hidden bit + mantissa + GRS
`define FP_EXP_MAX (2*`FP_BIAS)           // Largest finite biased exponent

`default_nettype wire

`endif

// File: logic/fpAlign.sv
`timescale 1ns/1ps
`include "fpAdd_macros.svh"
`default_nettype none

module fpAlign (
	input  logic                     signA,
	input  logic                     signB,
	input  logic [2*`FP_EXP_W-1:0]   shiftDet,
	input  fpFormatPkg::fpMag_t      magA,
	input  fpFormatPkg::fpMag_t      magB,
	input  fpAddCtrlPkg::fpOp_e      opIn,
	output logic [`FP_SIG_W-1:0]     largeMan,   // Hidden bit, fraction, GRS
	output logic [`FP_SIG_W-1:0]     smallMan,   // Aligned to largeMan
	output logic [`FP_EXP_W-1:0]     baseExp,
	output logic                     largeSign,  // Effective sign of larger operand
	output logic                     smallSign,  // Smaller sign, effective after op flip
	output fpAddCtrlPkg::fpOp_e      opOut
);
	import fpAddCtrlPkg::*;

	logic                    aLarger;      // |A| >= |B|
	logic                    effSignB;     // B sign after op
	logic [`FP_EXP_W-1:0]    expA, expB;
	logic [`FP_SIG_W-1:0]    sigA, sigB;   // Unshifted significands
	logic [`FP_SIG_W-1:0]    smallRaw;
	logic [`FP_EXP_W-1:0]    shiftAmt;
	logic [2*`FP_SIG_W-1:0]  shiftExt;     // Upper half kept, lower half shifted out

	assign expA = magA[`FP_WIDTH-2:`FP_MAN_W];
	assign expB = magB[`FP_WIDTH-2:`FP_MAN_W];

	// Zero exponent means zero, subnormals included
	assign sigA = (expA != '0) ? {1'b1, magA[`FP_MAN_W-1:0], {`FP_GRS_W{1'b0}}} : '0;
	assign sigB = (expB != '0) ? {1'b1, magB[`FP_MAN_W-1:0], {`FP_GRS_W{1'b0}}} : '0;

	assign aLarger  = (magA >= magB);  // Exp then fraction, plain compare works
	assign effSignB = signB ^ (opIn == opSub);

	assign largeMan  = aLarger ? sigA : sigB;
	assign smallRaw  = aLarger ? sigB : sigA;
	assign baseExp   = aLarger ? expA : expB;
	assign largeSign = aLarger ? signA : effSignB;
	assign smallSign = aLarger ? signB : signA ^ (opIn == opSub);  // A pre-flipped, op flip restores it
	assign shiftAmt  = aLarger ? shiftDet[`FP_EXP_W-1:0] : shiftDet[2*`FP_EXP_W-1:`FP_EXP_W];

	assign shiftExt = {smallRaw, {`FP_SIG_W{1'b0}}} >> shiftAmt;

	always_comb begin
		if (shiftAmt >= `FP_SIG_W) begin
			smallMan = {{(`FP_SIG_W-1){1'b0}}, |smallRaw};  // Everything gone, sticky only
		end else begin
			smallMan = {shiftExt[2*`FP_SIG_W-1:`FP_SIG_W+1],
				shiftExt[`FP_SIG_W] | (|shiftExt[`FP_SIG_W-1:0])};  // Fold lost bits into sticky
		end
	end

	assign opOut = opIn;

endmodule

`default_nettype wire

// File: logic/fpExecute.sv
`timescale 1ns/1ps
`include "fpAdd_macros.svh"
`default_nettype none

module fpExecute (
	input  logic [`FP_SIG_W-1:0]  largeMan,
	input  logic [`FP_SIG_W-1:0]  smallMan,
	input  logic                  largeSign,
	input  logic                  smallSign,
	input  fpAddCtrlPkg::fpOp_e   op,
	output logic [`FP_SIG_W:0]    sumMan,   // One carry bit on top
	output logic                  sumSign
);
	import fpAddCtrlPkg::*;

	logic effSub;      // Signs differ once op is applied
	logic zeroDiff;    // Exact cancellation

	// XOR is symmetric so the swap does not matter here
	assign effSub = largeSign ^ smallSign ^ (op == opSub);

	always_comb begin
		if (effSub) begin
			sumMan = {1'b0, largeMan} - {1'b0, smallMan};  // Never negative, large >= small
		end else begin
			sumMan = {1'b0, largeMan} + {1'b0, smallMan};
		end
	end

	assign zeroDiff = effSub && (sumMan == '0);

	// x - x is +0 under round to nearest
	assign sumSign = zeroDiff ? 1'b0 : largeSign;

endmodule

`default_nettype wire

// File: logic/fpFormatPkg.sv
`include "fpAdd_macros.svh"
`default_nettype none

package fpFormatPkg;

	// Field view of one binary16 word
	typedef struct packed {
		logic                 sign;  // Sign bit
		logic [`FP_EXP_W-1:0] exp;   // Biased exponent
		logic [`FP_MAN_W-1:0] man;   // Fraction without hidden bit
	} fpFields_t;

	// Same word seen as raw bits or as fields
	typedef union packed {
		logic [`FP_WIDTH-1:0] bits;  // Port view
		fpFields_t            f;     // Decode view
	} fpWord_u;

	// Exponent and mantissa with the sign stripped
	typedef logic [`FP_WIDTH-2:0] fpMag_t;

endpackage

`default_nettype wire

// File: logic/fpNormalizeRound.sv
`timescale 1ns/1ps
`include "fpAdd_macros.svh"
`default_nettype none

module fpNormalizeRound (
	input  logic [`FP_SIG_W:0]       sumMan,
	input  logic                     sumSign,
	input  logic [`FP_EXP_W-1:0]     baseExp,
	input  fpAddCtrlPkg::inputExc_t  inputExc,
	input  logic                     signA,
	input  logic                     signB,
	input  fpAddCtrlPkg::fpOp_e      op,
	output fpFormatPkg::fpWord_u     result,
	output fpAddCtrlPkg::resultFlags_t flags
);
	import fpAddCtrlPkg::*;

	logic                        effSignB;   // B sign after op
	logic                        infClash;   // inf - inf
	logic                        carry;      // Sum spilled into top bit
	logic                        sumZero;
	logic [3:0]                  lzCount;    // Leading zeros below carry bit
	logic [`FP_SIG_W-1:0]        normMan;    // Hidden bit at MSB
	logic signed [`FP_EXP_W+1:0] expNorm;
	logic signed [`FP_EXP_W+1:0] expRound;
	logic                        lsbBit, guardBit, roundBit, stickyBit;
	logic                        roundUp;
	logic [`FP_MAN_W:0]          manRound;   // Extra bit catches round carry

	assign effSignB = signB ^ (op == opSub);
	assign infClash = inputExc.aInf & inputExc.bInf & (signA ^ effSignB);
	assign carry    = sumMan[`FP_SIG_W];
	assign sumZero  = (sumMan == '0);

	// Priority search from the top
	always_comb begin
		logic found;
		found   = 1'b0;
		lzCount = '0;
		for (int i = `FP_SIG_W - 1; i >= 0; i--) begin
			if (!found && sumMan[i]) begin
				lzCount = 4'(`FP_SIG_W - 1 - i);
				found   = 1'b1;
			end
		end
	end

	always_comb begin
		if (carry) begin
			normMan = {sumMan[`FP_SIG_W:2], sumMan[1] | sumMan[0]};  // Shift right, keep sticky
		end else begin
			normMan = sumMan[`FP_SIG_W-1:0] << lzCount;
		end
	end

	assign expNorm = $signed({2'b00, baseExp}) + $signed({6'b0, carry})
		- $signed({3'b000, lzCount});

	// Round to nearest even
	assign lsbBit    = normMan[`FP_GRS_W];
	assign guardBit  = normMan[`FP_GRS_W-1];
	assign roundBit  = normMan[`FP_GRS_W-2];
	assign stickyBit = normMan[0];
	assign roundUp   = guardBit & (roundBit | stickyBit | lsbBit);
	assign manRound  = {1'b0, normMan[`FP_SIG_W-2:`FP_GRS_W]} + {{`FP_MAN_W{1'b0}}, roundUp};
	assign expRound  = expNorm + $signed({6'b0, manRound[`FP_MAN_W]});  // 1.11..1 rounds to 10.0

	always_comb begin
		result = '0;
		flags  = '0;
		if (inputExc.aNaN | inputExc.bNaN | infClash) begin
			result.f.exp = '1;                                  // Quiet NaN 7E00
			result.f.man = {1'b1, {(`FP_MAN_W-1){1'b0}}};
			flags.invalid = 1'b1;
		end else if (inputExc.anyExc) begin
			result.f.sign = inputExc.aInf ? signA : effSignB;   // Infinity passes through
			result.f.exp  = '1;
		end else if (sumZero) begin
			result.f.sign = sumSign;                            // Exact zero, no flag
		end else if (expRound > `FP_EXP_MAX) begin
			result.f.sign  = sumSign;
			result.f.exp   = '1;
			flags.overflow = 1'b1;
		end else if (expRound < 1) begin
			result.f.sign   = sumSign;                          // Flush to zero
			flags.underflow = 1'b1;
		end else begin
			result.f.sign = sumSign;
			result.f.exp  = expRound[`FP_EXP_W-1:0];
			result.f.man  = manRound[`FP_MAN_W-1:0];            // Zero after round carry
		end
	end

endmodule

`default_nettype wire

// File: logic/fpPrealign.sv
`timescale 1ns/1ps
`include "fpAdd_macros.svh"
`default_nettype none

module fpPrealign (
	input  fpFormatPkg::fpWord_u     a,
	input  fpFormatPkg::fpWord_u     b,
	input  fpAddCtrlPkg::fpOp_e      op,
	output logic                     signA,
	output logic                     signB,
	output logic [2*`FP_EXP_W-1:0]   shiftDet,  // {B-A, A-B}
	output fpAddCtrlPkg::inputExc_t  inputExc,
	output fpFormatPkg::fpMag_t      magA,
	output fpFormatPkg::fpMag_t      magB,
	output fpAddCtrlPkg::fpOp_e      opOut
);
	import fpFormatPkg::*;

	fpFields_t fldA;                // Field view of a
	fpFields_t fldB;                // Field view of b
	logic      aNaN, bNaN;          // All-ones exponent, nonzero fraction
	logic      aInf, bInf;          // All-ones exponent, zero fraction
	logic [`FP_EXP_W-1:0] diffAB;   // ExpA - ExpB
	logic [`FP_EXP_W-1:0] diffBA;   // ExpB - ExpA

	assign fldA = a.f;
	assign fldB = b.f;

	assign aNaN = (&fldA.exp) & (|fldA.man);
	assign bNaN = (&fldB.exp) & (|fldB.man);
	assign aInf = (&fldA.exp) & ~(|fldA.man);
	assign bInf = (&fldB.exp) & ~(|fldB.man);

	assign inputExc = '{anyExc: aNaN | bNaN | aInf | bInf,
		aNaN: aNaN, bNaN: bNaN, aInf: aInf, bInf: bInf};

	// Both differences wrap mod 32, the larger side picks one later
	assign diffAB = fldA.exp - fldB.exp;
	assign diffBA = fldB.exp - fldA.exp;
	assign shiftDet = {diffBA, diffAB};

	assign signA = fldA.sign;
	assign signB = fldB.sign;
	assign magA  = a.bits[`FP_WIDTH-2:0];  // Drop sign
	assign magB  = b.bits[`FP_WIDTH-2:0];
	assign opOut = op;                     // Op rides along

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# Build the fpAddSub testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-f fpAddSub.f \
	--top-module fpAddSubTb \
	-Mdir obj_dir \
	-o fpAddSubSim
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
	echo "Verilator build stopped with status $buildStatus"
	exit "$buildStatus"
fi

./obj_dir/fpAddSubSim
simStatus=$?
if [ "$simStatus" -ne 0 ]; then
	echo "Simulation ended with status $simStatus"
	exit "$simStatus"
fi

exit 0

// File: verification/fpAddSubVectors.svh
// Columns: name, a, b, op, expected result, expected flags {invalid, overflow, underflow}
// Operands and results are raw binary16 words in hex
`ifndef FPADDSUBVECTORS_SVH
`define FPADDSUBVECTORS_SVH

task automatic fillTable();
	addVec("addOnePlusTwo",    16'h3C00, 16'h4000, opAdd, 16'h4200, 3'b000);  // 1 + 2 = 3
	addVec("subOneMinusThree", 16'h3C00, 16'h4200, opSub, 16'hC000, 3'b000);  // 1 - 3 = -2
	addVec("subNegNeg",        16'hC200, 16'hBC00, opSub, 16'hC000, 3'b000);  // -3 - -1 = -2
	addVec("addNegPos",        16'hBC00, 16'h4200, opAdd, 16'h4000, 3'b000);  // -1 + 3 = 2
	addVec("tieEvenStays",     16'h6800, 16'h3C00, opAdd, 16'h6800, 3'b000);  // 2048 + 1, even kept
	addVec("tieOddRoundsUp",   16'h6801, 16'h3C00, opAdd, 16'h6802, 3'b000);  // 2050 + 1 to 2052
	addVec("aboveHalfUp",      16'h6800, 16'h3E00, opAdd, 16'h6801, 3'b000);  // 2048 + 1.5 to 2050
	addVec("stickyOnlyAdd",    16'h3C00, 16'h0400, opAdd, 16'h3C00, 3'b000);  // Shift of 14
	addVec("stickyOnlySub",    16'h3C00, 16'h0400, opSub, 16'h3C00, 3'b000);  // Borrow then round up
	addVec("selfCancel",       16'h3E00, 16'h3E00, opSub, 16'h0000, 3'b000);  // x - x = +0
	addVec("nearEqualSameExp", 16'h3C01, 16'h3C00, opSub, 16'h1400, 3'b000);  // One ulp left
	addVec("nearEqualCross",   16'h4000, 16'h3FFF, opSub, 16'h1400, 3'b000);  // 2 - (2 - 2^-10)
	addVec("maxOverflow",      16'h7BFF, 16'h7BFF, opAdd, 16'h7C00, 3'b010);  // 65504 + 65504
	addVec("underflowPos",     16'h0401, 16'h0400, opSub, 16'h0000, 3'b001);  // 2^-24 flushed
	addVec("underflowNeg",     16'h8401, 16'h8400, opSub, 16'h8000, 3'b001);  // -2^-24 flushed
	addVec("nanOnA",           16'h7C01, 16'h3C00, opAdd, 16'h7E00, 3'b100);
	addVec("nanOnB",           16'h3C00, 16'hFE00, opSub, 16'h7E00, 3'b100);
	addVec("infMinusInf",      16'h7C00, 16'h7C00, opSub, 16'h7E00, 3'b100);
	addVec("infPlusNegInf",    16'h7C00, 16'hFC00, opAdd, 16'h7E00, 3'b100);
	addVec("negInfPlusThree",  16'hFC00, 16'h4200, opAdd, 16'hFC00, 3'b000);  // Inf passes through
	addVec("oneMinusInf",      16'h3C00, 16'h7C00, opSub, 16'hFC00, 3'b000);  // Sign from op
endtask

`endif

// File: verification/fpAddSubTb.sv
`timescale 1ns/1ps
`include "fpAdd_macros.svh"
`default_nettype none

module fpAddSubTb;
	import fpFormatPkg::*;
	import fpAddCtrlPkg::*;

	localparam int LATENCY    = 3;   // Register stages in the DUT
	localparam int WAIT_LIMIT = 20;  // Cycles allowed for the pipeline to drain

	logic         clk;
	logic         rstN;
	logic         inVal;
	logic         outVal;
	fpWord_u      a;
	fpWord_u      b;
	fpOp_e        op;
	fpWord_u      result;
	resultFlags_t flags;

	integer seed = 32'h9be3_8ec4;  // Gap pattern source
	int     cycleCount = 0;

	string        vecName[$];   // Table columns
	fpWord_u      vecA[$];
	fpWord_u      vecB[$];
	fpOp_e        vecOp[$];
	fpWord_u      vecRes[$];
	resultFlags_t vecFlags[$];
	int           expQ[$];      // Table index per issued operation
	int           strobeQ[$];   // Cycle of each strobe seen

	fpAddSub u_dut (
		.clk(clk), .rstN(rstN), .inVal(inVal), .a(a), .b(b), .op(op),
		.outVal(outVal), .result(result), .flags(flags)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;  // 20 ns period
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	always @(negedge clk) begin
		if (rstN && inVal) begin
			strobeQ.push_back(cycleCount);  // Stamp for latency check
		end
	end

	// Each result pops the oldest operation in flight
	always @(negedge clk) begin
		if (rstN && outVal === 1'b1) begin
			checkResult();
		end
	end

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic addVec(input string name, input logic [`FP_WIDTH-1:0] aBits,
			input logic [`FP_WIDTH-1:0] bBits, input fpOp_e vop,
			input logic [`FP_WIDTH-1:0] resBits, input resultFlags_t flg);
		vecName.push_back(name);
		vecA.push_back(aBits);
		vecB.push_back(bBits);
		vecOp.push_back(vop);
		vecRes.push_back(resBits);
		vecFlags.push_back(flg);
	endtask

	`include "fpAddSubVectors.svh"

	task automatic checkWord(input string name, input fpWord_u expected, input fpWord_u actual);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL %s result expected %h actual %h",
				name, expected.bits, actual.bits));
		end
	endtask

	task automatic checkFlags(input string name, input resultFlags_t expected,
			input resultFlags_t actual);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL %s flags expected %b actual %b", name, expected, actual));
		end
	endtask

	task automatic compareLatency(input string name, input int expected, input int actual);
		if (actual != expected) begin
			abortRun($sformatf("FAIL %s latency expected %0d actual %0d", name, expected, actual));
		end
	endtask

	task automatic checkResult();
		int idx;
		int strobeAt;
		if (expQ.size() == 0 || strobeQ.size() == 0) begin
			abortRun("a result arrived with no operation outstanding");
		end else begin
			idx      = expQ.pop_front();
			strobeAt = strobeQ.pop_front();
			compareLatency(vecName[idx], LATENCY, cycleCount - strobeAt);
			checkWord(vecName[idx], vecRes[idx], result);
			checkFlags(vecName[idx], vecFlags[idx], flags);
		end
	endtask

	// Bounded wait for the last results
	task automatic waitDrain();
		int count;
		count = 0;
		while (expQ.size() != 0 && count < WAIT_LIMIT) begin
			@(posedge clk);
			count++;
		end
	endtask

	task automatic driveTable(input bit gaps);
		int          i;
		int          idle;
		logic [31:0] pick;
		for (i = 0; i < vecName.size(); i++) begin
			@(posedge clk);
			inVal <= 1'b1;
			a     <= vecA[i];
			b     <= vecB[i];
			op    <= vecOp[i];
			expQ.push_back(i);
			idle = 0;
			if (gaps) begin
				pick = $random(seed);
				idle = pick[0] ? 0 : 1 + pick[1];  // 0, 1 or 2 idle cycles
			end
			repeat (idle) begin
				@(posedge clk);
				inVal <= 1'b0;
			end
		end
	endtask

	initial begin
		rstN  = 1'b0;
		inVal = 1'b0;
		a     = '0;
		b     = '0;
		op    = opAdd;
		fillTable();
		repeat (2) @(posedge clk);
		rstN <= 1'b1;  // Two cycles in reset
		repeat (3) begin
			@(negedge clk);
			if (outVal !== 1'b0) begin
				abortRun("outVal went high before any strobe");
			end
		end
		driveTable(1'b1);  // Random gaps
		driveTable(1'b0);  // Back to back stream
		@(posedge clk);
		inVal <= 1'b0;
		waitDrain();
		repeat (4) begin
			@(negedge clk);
			if (outVal !== 1'b0) begin
				abortRun("outVal high after the stream drained");
			end
		end
		if (expQ.size() == 0 && strobeQ.size() == 0) begin
			$display("test passed");
			$finish;
		end else begin
			abortRun("no result arrived within the wait limit");
		end
	end

endmodule

`default_nettype wire
